/* design/rand_delay_pkg.sv */
// Shared widths, counts and helper functions for the random-delay
// message chain checker

package rand_delay_pkg;

  // Widths and counts
  localparam int msg_nbits   = 8;
  localparam int num_msgs    = 64;
  localparam int count_nbits = 16;
  localparam int num_stages  = 3;
  localparam int lfsr_nbits  = 16;
  localparam int mask_nbits  = 4;

  // Stage FSM encodings
  localparam logic [1:0] stage_empty   = 2'd0;
  localparam logic [1:0] stage_waiting = 2'd1;
  localparam logic [1:0] stage_full    = 2'd2;

  // Message number i of the known sequence, i*37+5 kept to msg width
  function automatic logic [msg_nbits-1:0] msg_for_index(input logic [count_nbits-1:0] i);
    logic [count_nbits-1:0] full;
    full = i * count_nbits'(37) + count_nbits'(5);
    return full[msg_nbits-1:0];
  endfunction

  // Fibonacci feedback from taps 15, 13, 12 and 10
  function automatic logic [lfsr_nbits-1:0] lfsr_step(input logic [lfsr_nbits-1:0] s);
    return {s[lfsr_nbits-2:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

endpackage

/* design/delay_lfsr.sv */
// Delay generator: 16-bit Fibonacci LFSR stepped on request, giving a
// wait count limited by a mask

`timescale 1ns/10ps

module delay_lfsr
#(
  parameter logic [rand_delay_pkg::lfsr_nbits-1:0] seed = 16'h0001
)(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 step,
  input  logic [rand_delay_pkg::mask_nbits-1:0] mask,
  output logic [rand_delay_pkg::mask_nbits-1:0] wait_count
);

  import rand_delay_pkg::*;

  // LFSR state, must never hold all zeros
  logic [lfsr_nbits-1:0] lfsr_q;

  always_ff @(posedge clk)
  begin
    if (reset)
      lfsr_q <= seed;
    else if (step)
      // One advance per drawn wait
      lfsr_q <= lfsr_step(lfsr_q);
  end

  // Low bits limited by the mask, so 0 to 15 cycles at most
  assign wait_count = lfsr_q[mask_nbits-1:0] & mask;

endmodule

/* design/rand_delay_source.sv */
// Message source: sends the known message sequence over val/rdy with
// random gaps, flags done after the last transfer

`timescale 1ns/10ps

module rand_delay_source
#(
  parameter logic [rand_delay_pkg::lfsr_nbits-1:0] seed = 16'hACE1
)(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [rand_delay_pkg::mask_nbits-1:0] delay_mask,
  output logic                                 val,
  input  logic                                 rdy,
  output logic [rand_delay_pkg::msg_nbits-1:0]  msg,
  output logic                                 done
);

  import rand_delay_pkg::*;

  logic                   started_q;
  logic [mask_nbits-1:0]  cnt_q;
  logic [count_nbits-1:0] idx_q;
  logic                   done_q;
  logic [mask_nbits-1:0]  wait_count;
  logic                   xfer;
  logic                   step;

  // Draw once after reset and once per transfer
  assign xfer = val && rdy;
  assign step = !started_q || xfer;

  delay_lfsr #(.seed(seed)) u_delay_lfsr
  (
    .clk        (clk),
    .reset      (reset),
    .step       (step),
    .mask       (delay_mask),
    .wait_count (wait_count)
  );

  //----------------------------------------------------------
  // Index, wait counter and done
  //----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      started_q <= 1'b0;
      cnt_q     <= '0;
      idx_q     <= '0;
      done_q    <= 1'b0;
    end
    else if (!started_q)
    begin
      // First wait of the run
      started_q <= 1'b1;
      cnt_q     <= wait_count;
    end
    else if (xfer)
    begin
      idx_q <= idx_q + 1'b1;
      cnt_q <= wait_count;
      if (idx_q == count_nbits'(num_msgs - 1))
        done_q <= 1'b1;
    end
    else if (cnt_q != '0)
      cnt_q <= cnt_q - 1'b1;
  end

  // Offer held steady while blocked since nothing moves without xfer
  assign val  = started_q && (cnt_q == '0) && !done_q;
  assign msg  = msg_for_index(idx_q);
  assign done = done_q;

endmodule

/* design/rand_delay_stage.sv */
// One-entry random-delay stage that holds each message for a drawn
// number of cycles before offering it downstream

`timescale 1ns/10ps

module rand_delay_stage
#(
  parameter logic [rand_delay_pkg::lfsr_nbits-1:0] seed = 16'h1D0F
)(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [rand_delay_pkg::mask_nbits-1:0] delay_mask,
  input  logic                                 in_val,
  output logic                                 in_rdy,
  input  logic [rand_delay_pkg::msg_nbits-1:0]  in_msg,
  output logic                                 out_val,
  input  logic                                 out_rdy,
  output logic [rand_delay_pkg::msg_nbits-1:0]  out_msg
);

  import rand_delay_pkg::*;

  logic [1:0]            state_q;
  logic [mask_nbits-1:0] cnt_q;
  logic [msg_nbits-1:0]  msg_q;
  logic [mask_nbits-1:0] wait_count;
  logic                  in_xfer;
  logic                  out_xfer;

  assign in_xfer  = in_val && in_rdy;
  assign out_xfer = out_val && out_rdy;

  // New wait drawn for each accepted message
  delay_lfsr #(.seed(seed)) u_delay_lfsr
  (
    .clk        (clk),
    .reset      (reset),
    .step       (in_xfer),
    .mask       (delay_mask),
    .wait_count (wait_count)
  );

  //----------------------------------------------------------
  // Empty / waiting / full FSM
  //----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= stage_empty;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        stage_empty:
          if (in_xfer)
          begin
            cnt_q <= wait_count;
            // Zero wait skips straight to offering
            state_q <= (wait_count == '0) ? stage_full : stage_waiting;
          end
        stage_waiting:
        begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == mask_nbits'(1))
            state_q <= stage_full;
        end
        stage_full:
          if (out_xfer)
            state_q <= stage_empty;
        default:
          state_q <= stage_empty;
      endcase
    end
  end

  // Payload latch
  always_ff @(posedge clk)
  begin
    if (in_xfer)
      msg_q <= in_msg;
  end

  assign in_rdy  = (state_q == stage_empty);
  assign out_val = (state_q == stage_full);
  assign out_msg = msg_q;

endmodule

/* design/rand_delay_sink.sv */
// Message sink: accepts messages with random stalls, checks each one
// against the known sequence, counts failures and flags done

`timescale 1ns/10ps

module rand_delay_sink
#(
  parameter logic [rand_delay_pkg::lfsr_nbits-1:0] seed = 16'h7A3B
)(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [rand_delay_pkg::mask_nbits-1:0]  delay_mask,
  input  logic                                  val,
  output logic                                  rdy,
  input  logic [rand_delay_pkg::msg_nbits-1:0]   msg,
  output logic [rand_delay_pkg::count_nbits-1:0] num_failed,
  output logic [rand_delay_pkg::count_nbits-1:0] num_received,
  output logic                                  done
);

  import rand_delay_pkg::*;

  logic                   started_q;
  logic [mask_nbits-1:0]  cnt_q;
  logic [count_nbits-1:0] rx_count_q;
  logic [count_nbits-1:0] fail_count_q;
  logic                   done_q;
  logic [mask_nbits-1:0]  wait_count;
  logic                   xfer;
  logic                   step;
  logic                   all_seen;

  assign xfer     = val && rdy;
  assign step     = !started_q || xfer;
  assign all_seen = (rx_count_q == count_nbits'(num_msgs));

  delay_lfsr #(.seed(seed)) u_delay_lfsr
  (
    .clk        (clk),
    .reset      (reset),
    .step       (step),
    .mask       (delay_mask),
    .wait_count (wait_count)
  );

  //----------------------------------------------------------
  // Stall counter, checker and counts
  //----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      started_q    <= 1'b0;
      cnt_q        <= '0;
      rx_count_q   <= '0;
      fail_count_q <= '0;
      done_q       <= 1'b0;
    end
    else
    begin
      if (!started_q)
      begin
        started_q <= 1'b1;
        cnt_q     <= wait_count;
      end
      else if (xfer)
      begin
        rx_count_q <= rx_count_q + 1'b1;
        cnt_q      <= wait_count;
        // Compare against the expected entry of the sequence
        if (msg != msg_for_index(rx_count_q))
          fail_count_q <= fail_count_q + 1'b1;
      end
      else if (cnt_q != '0)
        cnt_q <= cnt_q - 1'b1;

      // One cycle behind the last transfer
      if (all_seen)
        done_q <= 1'b1;
    end
  end

  // Rdy stays low once the whole sequence has arrived
  assign rdy          = started_q && (cnt_q == '0) && !all_seen;
  assign num_received = rx_count_q;
  assign num_failed   = fail_count_q;
  assign done         = done_q;

endmodule

/* design/rand_delay_chain_top.sv */
// Chain top: message source, a row of random-delay stages and the
// checking sink, joined by val/rdy links

`timescale 1ns/10ps

module rand_delay_chain_top
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [rand_delay_pkg::mask_nbits-1:0]  src_delay_mask,
  input  logic [rand_delay_pkg::mask_nbits-1:0]  stage_delay_mask,
  input  logic [rand_delay_pkg::mask_nbits-1:0]  sink_delay_mask,
  output logic                                  out_val,
  output logic                                  out_rdy,
  output logic [rand_delay_pkg::msg_nbits-1:0]   out_msg,
  output logic [rand_delay_pkg::count_nbits-1:0] num_failed,
  output logic [rand_delay_pkg::count_nbits-1:0] num_received,
  output logic                                  done
);

  import rand_delay_pkg::*;

  // Link k joins block k to block k+1, link 0 leaves the source
  logic                 link_val [0:num_stages];
  logic                 link_rdy [0:num_stages];
  logic [msg_nbits-1:0] link_msg [0:num_stages];

  logic src_done;
  logic sink_done;

  rand_delay_source #(.seed(16'hACE1)) u_rand_delay_source
  (
    .clk        (clk),
    .reset      (reset),
    .delay_mask (src_delay_mask),
    .val        (link_val[0]),
    .rdy        (link_rdy[0]),
    .msg        (link_msg[0]),
    .done       (src_done)
  );

  //----------------------------------------------------------
  // Delay stages
  //----------------------------------------------------------

  for (genvar k = 0; k < num_stages; k++)
  begin : g_stage
    // Distinct seed per stage
    rand_delay_stage #(.seed(lfsr_nbits'(16'h1D0F + k))) u_rand_delay_stage
    (
      .clk        (clk),
      .reset      (reset),
      .delay_mask (stage_delay_mask),
      .in_val     (link_val[k]),
      .in_rdy     (link_rdy[k]),
      .in_msg     (link_msg[k]),
      .out_val    (link_val[k+1]),
      .out_rdy    (link_rdy[k+1]),
      .out_msg    (link_msg[k+1])
    );
  end

  rand_delay_sink #(.seed(16'h7A3B)) u_rand_delay_sink
  (
    .clk          (clk),
    .reset        (reset),
    .delay_mask   (sink_delay_mask),
    .val          (link_val[num_stages]),
    .rdy          (link_rdy[num_stages]),
    .msg          (link_msg[num_stages]),
    .num_failed   (num_failed),
    .num_received (num_received),
    .done         (sink_done)
  );

  // Sink-side link made visible to the testbench
  assign out_val = link_val[num_stages];
  assign out_rdy = link_rdy[num_stages];
  assign out_msg = link_msg[num_stages];

  assign done = src_done && sink_done;

endmodule

/* sim/rand_delay_chain_assertions.sv */
// Bound checks on the chain top for sink-side offer stability, done held
// high outside reset and no offer while reset is applied

`timescale 1ns/10ps

module rand_delay_chain_assertions
(
  input logic                                 clk,
  input logic                                 reset,
  input logic                                 out_val,
  input logic                                 out_rdy,
  input logic [rand_delay_pkg::msg_nbits-1:0] out_msg,
  input logic                                 done
);

  // Number of failed checks in this run
  int fail_count = 0;

  // A pending offer keeps val and payload until accepted
  offer_held: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_msg))
    else
    begin
      $error("out_val or out_msg changed while waiting for out_rdy");
      fail_count++;
    end

  // Done is sticky until the next reset
  done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
    else
    begin
      $error("done fell while reset was low");
      fail_count++;
    end

  // First reset edge clears the stage FSMs, so skip that one
  no_offer_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !out_val)
    else
    begin
      $error("out_val high during reset");
      fail_count++;
    end

endmodule

bind rand_delay_chain_top rand_delay_chain_assertions u_rand_delay_chain_assertions (.*);

/* sim/rand_delay_chain_tb.sv */
// Testbench for the random-delay message chain with fixed and random delay
// masks, a transfer-counting model of the message sequence and a watchdog

`timescale 1ns/10ps

module rand_delay_chain_tb;

  import rand_delay_pkg::*;

  localparam int num_tests  = 6;
  localparam int clk_period = 20;
  // Budget of 16 cycles per message per chain element over all tests
  localparam int limit_ns   = num_tests * num_msgs * 16 * (num_stages + 2) * clk_period;

  logic                   clk;
  logic                   reset;
  logic [mask_nbits-1:0]  src_delay_mask;
  logic [mask_nbits-1:0]  stage_delay_mask;
  logic [mask_nbits-1:0]  sink_delay_mask;
  logic                   out_val;
  logic                   out_rdy;
  logic [msg_nbits-1:0]   out_msg;
  logic [count_nbits-1:0] num_failed;
  logic [count_nbits-1:0] num_received;
  logic                   done;

  int errors       = 0;
  int failed_tests = 0;
  int model_count  = 0;

  rand_delay_chain_top u_rand_delay_chain_top
  (
    .clk              (clk),
    .reset            (reset),
    .src_delay_mask   (src_delay_mask),
    .stage_delay_mask (stage_delay_mask),
    .sink_delay_mask  (sink_delay_mask),
    .out_val          (out_val),
    .out_rdy          (out_rdy),
    .out_msg          (out_msg),
    .num_failed       (num_failed),
    .num_received     (num_received),
    .done             (done)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //------------------------------------------------------------
  // Model and compare tasks
  //------------------------------------------------------------

  // Message n of the sequence is n*37+5 cut to the message width
  function automatic logic [msg_nbits-1:0] expected_msg(input int n);
    int v;
    v = n * 37 + 5;
    return msg_nbits'(v);
  endfunction

  // Compare-task errors plus failed bound assertions
  function automatic int total_errors();
    return errors + u_rand_delay_chain_top.u_rand_delay_chain_assertions.fail_count;
  endfunction

  task automatic check_msg(input string name, input logic [msg_nbits-1:0] exp,
                           input logic [msg_nbits-1:0] act);
    if (act !== exp)
    begin
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [count_nbits-1:0] exp,
                             input logic [count_nbits-1:0] act);
    if (act !== exp)
    begin
      $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // Sampled mid-cycle before the edge that completes the transfer
  always @(negedge clk)
  begin
    if (reset)
      model_count = 0;
    else
    begin
      if (out_val && out_rdy)
      begin
        check_msg("out_msg", expected_msg(model_count), out_msg);
        model_count++;
      end
      check_count("num_failed", '0, num_failed);
    end
  end

  //------------------------------------------------------------
  // One full run from reset to done
  //------------------------------------------------------------

  task automatic run_test(input int num, input logic [mask_nbits-1:0] src_m,
                          input logic [mask_nbits-1:0] stage_m,
                          input logic [mask_nbits-1:0] sink_m);
    int start_errors;
    int cycles;
    start_errors = total_errors();
    cycles = 0;
    @(posedge clk);
    reset            <= 1'b1;
    src_delay_mask   <= src_m;
    stage_delay_mask <= stage_m;
    sink_delay_mask  <= sink_m;
    repeat (15) @(posedge clk);
    // Everything cleared before the run starts
    @(negedge clk);
    check_flag("done", 1'b0, done);
    check_count("num_received", '0, num_received);
    check_count("num_failed", '0, num_failed);
    @(posedge clk);
    reset <= 1'b0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!done);
    // Sink holds rdy low by now, so the model count is settled
    check_count("num_received", count_nbits'(num_msgs), num_received);
    check_count("num_received vs model", count_nbits'(model_count), num_received);
    check_count("num_failed", '0, num_failed);
    if (total_errors() != start_errors)
      failed_tests++;
    $display("test %0d: masks src %0d stage %0d sink %0d, %0d cycles, %0d errors",
             num, src_m, stage_m, sink_m, cycles, total_errors() - start_errors);
  endtask

  initial
  begin
    reset            <= 1'b1;
    src_delay_mask   <= '0;
    stage_delay_mask <= '0;
    sink_delay_mask  <= '0;
    void'($urandom(18));
    run_test(1, 4'd0, 4'd0, 4'd0);
    run_test(2, 4'd15, 4'd15, 4'd15);
    for (int t = 3; t <= num_tests; t++)
      run_test(t, mask_nbits'($urandom), mask_nbits'($urandom), mask_nbits'($urandom));
    $display("tests run %0d, tests failed %0d, errors %0d",
             num_tests, failed_tests, total_errors());
    if (total_errors() == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog for a chain that never finishes
  initial
  begin
    #(limit_ns);
    $display("timeout: done never rose");
    $display("Something failed");
    $finish;
  end

endmodule

/* sources.f */
design/rand_delay_pkg.sv
design/delay_lfsr.sv
design/rand_delay_source.sv
design/rand_delay_stage.sv
design/rand_delay_sink.sv
design/rand_delay_chain_top.sv
sim/rand_delay_chain_assertions.sv
sim/rand_delay_chain_tb.sv
